// File: verilog/div_pkg.sv
/* shared types and operation codes for the RV64M iterative divider
   operand/result word, one-hot op code, iteration count, core states, credit count */
package div_pkg;

  // ==================================================
  // data widths
  // ==================================================
  typedef logic [63:0] xlen_t;        // operand, result and remainder word
  typedef logic [7:0]  div_op_t;      // one-hot operation code
  typedef logic [6:0]  iter_cnt_t;    // 0 .. 64 iterations
  typedef logic [3:0]  credit_cnt_t;  // result credits, up to 15

  // ==================================================
  // core states
  // ==================================================
  typedef enum logic [1:0] {
    DIV_IDLE,  // waiting for a request
    DIV_RUN,   // one quotient bit per cycle
    DIV_DONE   // result held until taken
  } div_state_t;

  // ==================================================
  // operation codes
  // ==================================================
  localparam div_op_t OP_DIV   = 8'b1000_0000;  // signed 64
  localparam div_op_t OP_DIVU  = 8'b0100_0000;  // unsigned 64
  localparam div_op_t OP_DIVUW = 8'b0010_0000;  // unsigned 32
  localparam div_op_t OP_DIVW  = 8'b0001_0000;  // signed 32
  localparam div_op_t OP_REM   = 8'b0000_1000;  // signed 64
  localparam div_op_t OP_REMU  = 8'b0000_0100;  // unsigned 64
  localparam div_op_t OP_REMUW = 8'b0000_0010;  // unsigned 32
  localparam div_op_t OP_REMW  = 8'b0000_0001;  // signed 32

endpackage

// File: verilog/div_operand_prep.sv
`timescale 1ns/1ns
/* operand stage: word sign extension, absolute values, sign flags,
   divide-by-zero and overflow detection with the RISC-V exception value */
module div_operand_prep import div_pkg::*; (
  input  div_op_t   op_i,
  input  xlen_t     dividend_i,
  input  xlen_t     divisor_i,
  output xlen_t     opa_o,
  output xlen_t     opb_o,
  output iter_cnt_t iters_o,
  output logic      q_neg_o,
  output logic      r_neg_o,
  output logic      exc_o,
  output xlen_t     exc_val_o
);

  logic  is_word;
  logic  is_signed;
  logic  is_rem;
  xlen_t a_word;    // low word sign-extended
  xlen_t b_word;
  xlen_t a_ext;
  xlen_t b_ext;
  logic  a_neg;
  logic  b_neg;
  xlen_t a_abs;
  xlen_t b_abs;
  xlen_t min_neg;
  logic  div_zero;
  logic  div_ovf;

  // ==================================================
  // operation family decode
  // ==================================================
  assign is_word   = |(op_i & (OP_DIVUW | OP_DIVW | OP_REMUW | OP_REMW));
  assign is_signed = |(op_i & (OP_DIV | OP_DIVW | OP_REM | OP_REMW));
  assign is_rem    = |(op_i & (OP_REM | OP_REMU | OP_REMUW | OP_REMW));

  assign a_word = {{32{dividend_i[31]}}, dividend_i[31:0]};
  assign b_word = {{32{divisor_i[31]}}, divisor_i[31:0]};

  assign a_ext = is_word ? (is_signed ? a_word : {32'b0, dividend_i[31:0]}) : dividend_i;
  assign b_ext = is_word ? (is_signed ? b_word : {32'b0, divisor_i[31:0]}) : divisor_i;

  // ==================================================
  // magnitudes and signs
  // ==================================================
  assign a_neg = is_signed & a_ext[63];
  assign b_neg = is_signed & b_ext[63];
  assign a_abs = a_neg ? (~a_ext + 64'd1) : a_ext;
  assign b_abs = b_neg ? (~b_ext + 64'd1) : b_ext;

  assign opa_o   = is_word ? {a_abs[31:0], 32'b0} : a_abs;  // word dividend sits high
  assign opb_o   = b_abs;
  assign iters_o = is_word ? iter_cnt_t'(32) : iter_cnt_t'(64);
  assign q_neg_o = a_neg ^ b_neg;
  assign r_neg_o = a_neg;  // remainder follows dividend

  // ==================================================
  // exceptions
  // ==================================================
  assign div_zero = is_word ? (divisor_i[31:0] == 32'b0) : (divisor_i == 64'b0);
  assign min_neg  = is_word ? 64'hFFFF_FFFF_8000_0000 : 64'h8000_0000_0000_0000;
  assign div_ovf  = is_signed & (a_ext == min_neg) & (&b_ext);
  assign exc_o    = div_zero | div_ovf;

  always_comb begin
    if (div_zero) begin
      exc_val_o = is_rem ? (is_word ? a_word : dividend_i) : '1;  // q = all ones
    end else begin
      exc_val_o = is_rem ? '0 : (is_word ? a_word : dividend_i);  // overflow
    end
  end

endmodule

// File: verilog/div_iter_core.sv
`timescale 1ns/1ns
/* restoring division core: state machine and 128-bit remainder/quotient
   shift register, one quotient bit per cycle */
module div_iter_core import div_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  div_op_t   op_i,
  input  xlen_t     opa_i,
  input  xlen_t     opb_i,
  input  iter_cnt_t iters_i,
  input  logic      q_neg_i,
  input  logic      r_neg_i,
  input  logic      exc_i,
  input  xlen_t     exc_val_i,
  input  logic      take_i,
  output logic      done_o,
  output div_op_t   op_o,
  output xlen_t     quot_o,
  output xlen_t     rem_o,
  output logic      q_neg_o,
  output logic      r_neg_o,
  output logic      exc_o
);

  div_state_t   state;
  iter_cnt_t    cnt;
  logic [127:0] rq;      // {remainder, quotient}
  xlen_t        dvsr;
  logic [65:0]  diff;    // shifted remainder minus divisor
  logic         accept;
  div_op_t      op_q;
  logic         q_neg_q;
  logic         r_neg_q;
  logic         exc_q;

  assign accept = start_i && (state == DIV_IDLE);
  assign diff   = {1'b0, rq[127:63]} - {2'b00, dvsr};  // 65-bit partial remainder

  // ==================================================
  // control
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= DIV_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (accept) begin
            cnt   <= iters_i;
            state <= exc_i ? DIV_DONE : DIV_RUN;  // exceptions skip the loop
          end
        end
        DIV_RUN: begin
          cnt <= cnt - iter_cnt_t'(1);
          if (cnt == iter_cnt_t'(1)) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (take_i) begin
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  // ==================================================
  // datapath
  // ==================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      rq      <= exc_i ? {64'b0, exc_val_i} : {64'b0, opa_i};
      dvsr    <= opb_i;
      op_q    <= op_i;
      q_neg_q <= q_neg_i;
      r_neg_q <= r_neg_i;
      exc_q   <= exc_i;
    end else if (state == DIV_RUN) begin
      if (diff[65]) begin
        rq <= {rq[126:0], 1'b0};               // restore
      end else begin
        rq <= {diff[63:0], rq[62:0], 1'b1};    // keep difference
      end
    end
  end

  assign done_o  = (state == DIV_DONE);
  assign op_o    = op_q;
  assign quot_o  = rq[63:0];
  assign rem_o   = rq[127:64];
  assign q_neg_o = q_neg_q;
  assign r_neg_o = r_neg_q;
  assign exc_o   = exc_q;

  // requester may only send while the core is idle
  a_start_idle: assert property (@(posedge clk) disable iff (rst_n)
    start_i |-> state == DIV_IDLE);
  a_op_onehot: assert property (@(posedge clk) disable iff (rst_n)
    start_i |-> $onehot(op_i));

endmodule

// File: verilog/div_result_fmt.sv
`timescale 1ns/1ns
/* result formatter: sign correction, quotient or remainder select,
   word sign extension */
module div_result_fmt import div_pkg::*; (
  input  div_op_t op_i,
  input  xlen_t   quot_i,
  input  xlen_t   rem_i,
  input  logic    q_neg_i,
  input  logic    r_neg_i,
  input  logic    exc_i,
  output xlen_t   data_o
);

  logic  is_word;
  logic  is_rem;
  xlen_t q_fix;
  xlen_t r_fix;
  xlen_t sel;

  assign is_word = |(op_i & (OP_DIVUW | OP_DIVW | OP_REMUW | OP_REMW));
  assign is_rem  = |(op_i & (OP_REM | OP_REMU | OP_REMUW | OP_REMW));

  // ==================================================
  // sign restore
  // ==================================================
  assign q_fix = q_neg_i ? (~quot_i + 64'd1) : quot_i;
  assign r_fix = r_neg_i ? (~rem_i + 64'd1) : rem_i;

  assign sel = is_rem ? r_fix : q_fix;

  always_comb begin
    if (exc_i) begin
      data_o = quot_i;  // exception value already final
    end else if (is_word) begin
      data_o = {{32{sel[31]}}, sel[31:0]};
    end else begin
      data_o = sel;
    end
  end

endmodule

// File: verilog/div_credit_ctrl.sv
`timescale 1ns/1ns
/* result credit counter, result valid gating and request credit return */
module div_credit_ctrl import div_pkg::*; #(
  parameter int RES_CREDITS = 2
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  done_i,
  input  logic  res_credit_i,
  input  xlen_t data_i,
  output logic  take_o,
  output logic  res_valid_o,
  output xlen_t res_data_o,
  output logic  req_credit_o
);

  credit_cnt_t credit_cnt;  // granted minus used
  logic        fire;

  // same-cycle grant may be spent at once
  assign fire = done_i && ((credit_cnt != '0) || res_credit_i);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      credit_cnt <= '0;
    end else begin
      credit_cnt <= credit_cnt + credit_cnt_t'(res_credit_i) - credit_cnt_t'(fire);
    end
  end

  assign take_o       = fire;
  assign res_valid_o  = fire;
  assign req_credit_o = fire;  // one request credit per result
  assign res_data_o   = fire ? data_i : '0;

  a_cnt_limit: assert property (@(posedge clk) disable iff (rst_n)
    credit_cnt <= RES_CREDITS);
  // a result waiting without credit stays in the core
  a_no_spend_at_zero: assert property (@(posedge clk) disable iff (rst_n)
    done_i && (credit_cnt == '0) && !res_credit_i |=> done_i);

endmodule

// File: verilog/div_unit_top.sv
`timescale 1ns/1ns
/* divider top: operand prep, iterative core, result formatter, credit control */
module div_unit_top import div_pkg::*; #(
  parameter int RES_CREDITS = 2
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    req_valid_i,
  input  div_op_t req_op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  input  logic    res_credit_i,
  output logic    res_valid_o,
  output xlen_t   res_data_o,
  output logic    req_credit_o
);

  // ==================================================
  // prep to core
  // ==================================================
  xlen_t     opa;
  xlen_t     opb;
  iter_cnt_t iters;
  logic      prep_q_neg;
  logic      prep_r_neg;
  logic      prep_exc;
  xlen_t     exc_val;

  // ==================================================
  // core to formatter and credit control
  // ==================================================
  logic      done;
  logic      take;
  div_op_t   core_op;
  xlen_t     quot;
  xlen_t     rem;
  logic      core_q_neg;
  logic      core_r_neg;
  logic      core_exc;
  xlen_t     fmt_data;

  div_operand_prep div_operand_prep_inst (
    .op_i       (req_op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .opa_o      (opa),
    .opb_o      (opb),
    .iters_o    (iters),
    .q_neg_o    (prep_q_neg),
    .r_neg_o    (prep_r_neg),
    .exc_o      (prep_exc),
    .exc_val_o  (exc_val)
  );

  div_iter_core div_iter_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (req_valid_i),
    .op_i      (req_op_i),
    .opa_i     (opa),
    .opb_i     (opb),
    .iters_i   (iters),
    .q_neg_i   (prep_q_neg),
    .r_neg_i   (prep_r_neg),
    .exc_i     (prep_exc),
    .exc_val_i (exc_val),
    .take_i    (take),
    .done_o    (done),
    .op_o      (core_op),
    .quot_o    (quot),
    .rem_o     (rem),
    .q_neg_o   (core_q_neg),
    .r_neg_o   (core_r_neg),
    .exc_o     (core_exc)
  );

  div_result_fmt div_result_fmt_inst (
    .op_i    (core_op),
    .quot_i  (quot),
    .rem_i   (rem),
    .q_neg_i (core_q_neg),
    .r_neg_i (core_r_neg),
    .exc_i   (core_exc),
    .data_o  (fmt_data)
  );

  div_credit_ctrl #(
    .RES_CREDITS (RES_CREDITS)
  ) div_credit_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .done_i       (done),
    .res_credit_i (res_credit_i),
    .data_i       (fmt_data),
    .take_o       (take),
    .res_valid_o  (res_valid_o),
    .res_data_o   (res_data_o),
    .req_credit_o (req_credit_o)
  );

endmodule

// File: verification/div_clk_gen.sv
`timescale 1ns/1ns
/* free-running testbench clock, 4 ns period */
module div_clk_gen #(
  parameter int HALF_PERIOD = 2
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

// File: verification/div_tb.sv
`timescale 1ns/1ns
/* divider testbench: file driven requests, random result credits,
   result and credit checks, cycle timeout */
module div_tb import div_pkg::*; ();

  localparam int RES_CREDITS = 2;
  localparam int MAX_TESTS   = 64;

  logic    clk;
  logic    rst_n;
  logic    req_valid_i;
  div_op_t req_op_i;
  xlen_t   dividend_i;
  xlen_t   divisor_i;
  logic    res_credit_i;
  logic    res_valid_o;
  xlen_t   res_data_o;
  logic    req_credit_o;

  string   test_name [MAX_TESTS];
  div_op_t test_op   [MAX_TESTS];
  xlen_t   test_a    [MAX_TESTS];
  xlen_t   test_b    [MAX_TESTS];
  xlen_t   test_exp  [MAX_TESTS];
  int      num_tests;

  int      pending [$];      // test indices in flight, oldest first
  int      idx;
  int      next_test;
  int      results;
  int      grants;           // result credits handed to the DUT
  int      cycles;
  int      cycle_limit;
  int      error_count;
  logic    have_req_credit;
  integer  seed;

  div_clk_gen div_clk_gen_inst (
    .clk_o (clk)
  );

  div_unit_top #(
    .RES_CREDITS (RES_CREDITS)
  ) div_unit_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .dividend_i   (dividend_i),
    .divisor_i    (divisor_i),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_data_o   (res_data_o),
    .req_credit_o (req_credit_o)
  );

  // ==================================================
  // reporting and checks
  // ==================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at cycle %0d", cycles);
  endtask

  task automatic check_data(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      error_count++;
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_credit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      error_count++;
      abort_run($sformatf("credit error at cycle %0d: %s", cycles, what));
    end
  endtask

  task automatic load_tests();
    int      fd;
    int      n;
    string   line;
    string   name;
    div_op_t op;
    xlen_t   a;
    xlen_t   b;
    xlen_t   e;
    fd = $fopen("verification/div_tests.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verification/div_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        n = $sscanf(line, "%s %h %h %h %h", name, op, a, b, e);
        if (n == 5 && name.getc(0) != "#" && num_tests < MAX_TESTS) begin  // skip comments
          test_name[num_tests] = name;
          test_op[num_tests]   = op;
          test_a[num_tests]    = a;
          test_b[num_tests]    = b;
          test_exp[num_tests]  = e;
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // ==================================================
  // sequence
  // ==================================================
  initial begin
    seed            = 32'h8290_44ad;
    rst_n           = 1'b1;
    req_valid_i     = 1'b0;
    req_op_i        = '0;
    dividend_i      = '0;
    divisor_i       = '0;
    res_credit_i    = 1'b0;
    num_tests       = 0;
    next_test       = 0;
    results         = 0;
    grants          = 0;
    cycles          = 0;
    error_count     = 0;
    have_req_credit = 1'b1;  // requester owns one credit after reset
    load_tests();
    if (num_tests == 0) begin
      abort_run("the tests file holds no tests");
    end else begin
      cycle_limit = num_tests * 80 + 200;
      repeat (8) @(posedge clk);
      rst_n <= 1'b0;
      while (results < num_tests) @(posedge clk);
      repeat (20) @(posedge clk);  // idle tail, no stray credit return
      if (error_count == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

  // sample at the edge, then drive the next cycle
  always @(posedge clk) begin
    if (!rst_n) begin
      cycles++;
      if (cycles > cycle_limit) begin
        abort_run($sformatf("timeout: only %0d of %0d results after %0d cycles",
                            results, num_tests, cycles));
      end else begin
        if (res_credit_i) grants++;  // same-cycle grant counts
        check_credit("request credit return does not match a result", res_valid_o,
                     req_credit_o);
        if (res_valid_o) begin
          check_credit("result sent without a granted result credit", 1'b1,
                       grants > results);
          if (pending.size() == 0) begin
            abort_run("result arrived with no request in flight");
          end else begin
            idx = pending.pop_front();
            check_data(test_name[idx], test_exp[idx], res_data_o);
            results++;
          end
        end
        if (req_credit_o) begin
          have_req_credit = 1'b1;
        end

        // random grants, withheld in a window to force back-pressure
        if ((grants - results) < RES_CREDITS && !(cycles >= 300 && cycles < 500)
            && ($random(seed) & 3) == 0) begin
          res_credit_i <= 1'b1;
        end else begin
          res_credit_i <= 1'b0;
        end

        if (have_req_credit && next_test < num_tests && cycles > 10) begin
          req_valid_i     <= 1'b1;
          req_op_i        <= test_op[next_test];
          dividend_i      <= test_a[next_test];
          divisor_i       <= test_b[next_test];
          pending.push_back(next_test);
          next_test++;
          have_req_credit = 1'b0;
        end else begin
          req_valid_i <= 1'b0;
        end
      end
    end
  end

endmodule

// File: verification/div_tests.txt
# columns: name, one-hot op code, dividend, divisor, expected result (all hex)
# op codes: 80 div, 40 divu, 20 divuw, 10 divw, 08 rem, 04 remu, 02 remuw, 01 remw
div_pp 80 0000000000000064 0000000000000007 000000000000000e
div_np 80 ffffffffffffff9c 0000000000000007 fffffffffffffff2
div_pn 80 0000000000000064 fffffffffffffff9 fffffffffffffff2
div_nn 80 ffffffffffffff9c fffffffffffffff9 000000000000000e
rem_pp 08 0000000000000064 0000000000000007 0000000000000002
rem_np 08 ffffffffffffff9c 0000000000000007 fffffffffffffffe
rem_pn 08 0000000000000064 fffffffffffffff9 0000000000000002
rem_nn 08 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
divu_big 40 ffffffffffffffff 0000000000000003 5555555555555555
remu_big 04 ffffffffffffffff 000000000000000a 0000000000000005
divw_neg 10 deadbeefffffff9c 1234567800000007 fffffffffffffff2
divuw_sx 20 01234567fffffffe 89abcdef00000001 fffffffffffffffe
remw_neg 01 13579bdfffffff9c 2468ace000000007 fffffffffffffffe
remuw_sx 02 7654321080000001 0000ffff90000000 ffffffff80000001
div_z0 80 000000000000007b 0000000000000000 ffffffffffffffff
divu_z0 40 000000000000007b 0000000000000000 ffffffffffffffff
rem_z0 08 ffffffffffffff85 0000000000000000 ffffffffffffff85
remu_z0 04 0123456789abcdef 0000000000000000 0123456789abcdef
divw_z0 10 000000000000007b ffffffff00000000 ffffffffffffffff
divuw_z0 20 cafef00d0000007b 0000000100000000 ffffffffffffffff
remw_z0 01 aaaaaaaa80000000 1234000000000000 ffffffff80000000
remuw_z0 02 5555555587654321 0000000000000000 ffffffff87654321
div_ovf 80 8000000000000000 ffffffffffffffff 8000000000000000
rem_ovf 08 8000000000000000 ffffffffffffffff 0000000000000000
divw_ovf 10 1234567880000000 00000000ffffffff ffffffff80000000
remw_ovf 01 9876543280000000 abcdef00ffffffff 0000000000000000

// File: list.f
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/div_iter_core.sv
verilog/div_result_fmt.sv
verilog/div_credit_ctrl.sv
verilog/div_unit_top.sv
verification/div_clk_gen.sv
verification/div_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the divider testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module div_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vdiv_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
